// File: design/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

`default_nettype none

// Datapath widths
`define PC_WIDTH        16
`define COUNT_WIDTH     16
`define OPCODE_WIDTH    4
`define COND_WIDTH      3
`define OFFSET_WIDTH    9

// Opcodes the front end decodes itself
`define OP_BRANCH       4'hC
`define OP_HALT         4'hF

`define PC_RESET        16'h0000
`define PC_STEP         16'h0002

// Bubble cycles after a taken branch, 1 or more
`define BRANCH_PENALTY  2

`default_nettype wire

`endif

// File: design/fetch_pkg.sv
`include "fetch_defs.svh"

`default_nettype none

package fetch_pkg;

	// Branch condition field, tested against N V Z
	typedef enum logic [`COND_WIDTH-1:0] {
		NEQ    = 3'b000,	// Not Z
		EQ     = 3'b001,	// Z
		GT     = 3'b010,	// Not Z and not N
		LT     = 3'b011,	// N
		GEQ    = 3'b100,	// Z or not N
		LEQ    = 3'b101,	// Z or N
		OVFL   = 3'b110,	// V
		UNCOND = 3'b111	// Always
	} cond_e;

	// Instruction word, cond and offset only meaningful for branches
	typedef struct packed {
		logic [`OPCODE_WIDTH-1:0]        opcode;
		cond_e                           cond;
		logic signed [`OFFSET_WIDTH-1:0] offset;	// Word offset
	} instr_t;

	typedef struct packed {
		logic n;
		logic v;
		logic z;
	} flags_t;

	typedef enum logic [1:0] {
		RUN    = 2'd0,
		BUBBLE = 2'd1,	// Waiting out the branch penalty
		HALTED = 2'd2
	} fetch_state_e;

endpackage

`default_nettype wire

// File: design/pc_control.sv
`include "fetch_defs.svh"

`default_nettype none

module pc_control import fetch_pkg::*; (
	input  instr_t                instr,
	input  flags_t                flags,
	input  logic [`PC_WIDTH-1:0]  pc,
	input  logic                  hlt,
	output logic [`PC_WIDTH-1:0]  next_pc,
	output logic                  taken
);

	logic                  neg_flag;
	logic                  ovfl_flag;
	logic                  zero_flag;
	logic                  is_branch;
	logic                  cond_met;
	logic [`PC_WIDTH-1:0]  pc_plus_2;
	logic [`PC_WIDTH-1:0]  offset_ext;
	logic [`PC_WIDTH-1:0]  offset_bytes;
	logic [`PC_WIDTH-1:0]  target;

	assign neg_flag  = flags.n;
	assign ovfl_flag = flags.v;
	assign zero_flag = flags.z;

	assign is_branch = (instr.opcode == `OP_BRANCH);

	// Condition table
	always_comb begin
		case (instr.cond)
			NEQ:     cond_met = ~zero_flag;
			EQ:      cond_met = zero_flag;
			GT:      cond_met = ~zero_flag & ~neg_flag;
			LT:      cond_met = neg_flag;
			GEQ:     cond_met = zero_flag | ~neg_flag;
			LEQ:     cond_met = zero_flag | neg_flag;
			OVFL:    cond_met = ovfl_flag;
			UNCOND:  cond_met = 1'b1;
			default: cond_met = 1'b0;
		endcase
	end

	assign taken = is_branch & cond_met;

	assign pc_plus_2 = pc + `PC_STEP;

	// Sign extend first, then scale words to bytes
	assign offset_ext = {{(`PC_WIDTH-`OFFSET_WIDTH){instr.offset[`OFFSET_WIDTH-1]}},
		instr.offset};
	assign offset_bytes = {offset_ext[`PC_WIDTH-2:0], 1'b0};

	assign target = pc_plus_2 + offset_bytes;

	always_comb begin
		if (hlt) begin
			next_pc = pc;	// Hold on halt
		end else if (taken) begin
			next_pc = target;
		end else begin
			next_pc = pc_plus_2;
		end
	end

endmodule

`default_nettype wire

// File: design/bubble_timer.sv
`include "fetch_defs.svh"

`default_nettype none

module bubble_timer (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	output logic done
);

	localparam int CNT_W = (`BRANCH_PENALTY > 1) ? $clog2(`BRANCH_PENALTY) : 1;
	localparam logic [CNT_W-1:0] LOAD_VAL = CNT_W'(`BRANCH_PENALTY - 1);

	logic [CNT_W-1:0] count;
	logic             busy;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy  <= 1'b0;
			count <= '0;
		end else if (start) begin
			busy  <= 1'b1;
			count <= LOAD_VAL;
		end else if (busy) begin
			if (count == '0) begin
				busy <= 1'b0;	// Last bubble cycle just ended
			end else begin
				count <= count - 1'b1;
			end
		end
	end

	assign done = busy & (count == '0);

endmodule

`default_nettype wire

// File: design/fetch_sequencer.sv
`include "fetch_defs.svh"

`default_nettype none

module fetch_sequencer import fetch_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  instr_t instr,
	input  logic   taken,
	input  logic   timer_done,
	output logic   hlt,
	output logic   retire,
	output logic   timer_start,
	output logic   halted
);

	fetch_state_e state;
	fetch_state_e state_nxt;
	logic         in_run;
	logic         is_halt_op;

	assign in_run     = (state == RUN);
	assign is_halt_op = (instr.opcode == `OP_HALT);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= RUN;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			RUN: begin
				if (is_halt_op) begin
					state_nxt = HALTED;
				end else if (taken) begin
					state_nxt = BUBBLE;
				end
			end
			BUBBLE: begin
				if (timer_done) begin
					state_nxt = RUN;	// Target issues next cycle
				end
			end
			HALTED: begin
				state_nxt = HALTED;	// Only reset leaves
			end
			default: begin
				state_nxt = RUN;
			end
		endcase
	end

	// One instruction per RUN cycle
	always_comb begin
		retire      = in_run;
		hlt         = in_run & is_halt_op;
		timer_start = in_run & taken;
		halted      = (state == HALTED);
	end

endmodule

`default_nettype wire

// File: design/pc_state.sv
`include "fetch_defs.svh"

`default_nettype none

module pc_state import fetch_pkg::*; (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    retire,
	input  logic [`PC_WIDTH-1:0]    next_pc,
	input  logic                    flags_write,
	input  flags_t                  flags_in,
	output logic [`PC_WIDTH-1:0]    pc,
	output flags_t                  flags,
	output logic [`COUNT_WIDTH-1:0] instr_count
);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= `PC_RESET;
		end else if (retire) begin
			pc <= next_pc;
		end
	end

	// Written by execute, seen by the next branch
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			flags <= '0;
		end else if (flags_write) begin
			flags <= flags_in;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			instr_count <= '0;
		end else if (retire) begin
			instr_count <= instr_count + 1'b1;	// Wraps
		end
	end

endmodule

`default_nettype wire

// File: design/fetch_top.sv
`include "fetch_defs.svh"

`default_nettype none

module fetch_top import fetch_pkg::*; (
	input  logic                    clk,
	input  logic                    rst_n,
	output logic [`PC_WIDTH-1:0]    imem_addr,
	input  instr_t                  imem_data,
	input  logic                    flags_write,
	input  flags_t                  flags_in,
	output logic                    issue,
	output logic [`PC_WIDTH-1:0]    issue_pc,
	output instr_t                  issue_instr,
	output logic                    halted,
	output logic [`COUNT_WIDTH-1:0] instr_count
);

	logic [`PC_WIDTH-1:0] pc;
	logic [`PC_WIDTH-1:0] next_pc;
	flags_t               flags;
	logic                 hlt;
	logic                 taken;
	logic                 retire;
	logic                 timer_start;
	logic                 timer_done;

	assign imem_addr   = pc;
	assign issue       = retire;
	assign issue_pc    = pc;
	assign issue_instr = imem_data;

	pc_state u_pc_state (
		.clk         (clk),
		.rst_n       (rst_n),
		.retire      (retire),
		.next_pc     (next_pc),
		.flags_write (flags_write),
		.flags_in    (flags_in),
		.pc          (pc),
		.flags       (flags),
		.instr_count (instr_count)
	);

	pc_control u_pc_control (
		.instr   (imem_data),
		.flags   (flags),
		.pc      (pc),
		.hlt     (hlt),
		.next_pc (next_pc),
		.taken   (taken)
	);

	fetch_sequencer u_fetch_sequencer (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr       (imem_data),
		.taken       (taken),
		.timer_done  (timer_done),
		.hlt         (hlt),
		.retire      (retire),
		.timer_start (timer_start),
		.halted      (halted)
	);

	bubble_timer u_bubble_timer (
		.clk   (clk),
		.rst_n (rst_n),
		.start (timer_start),
		.done  (timer_done)
	);

endmodule

`default_nettype wire

// File: dv/fetch_tb.sv
`include "fetch_defs.svh"

`default_nettype none

module fetch_tb import fetch_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int WATCHDOG_CYCLES = 3 + 400 * (`BRANCH_PENALTY + 1) + 60;
	localparam logic [`PC_WIDTH-1:0] HALT_ADDR = 16'h000A;	// Word 5 of the phase two program

	logic                    clk = 1'b0;
	logic                    rst_n;
	logic [`PC_WIDTH-1:0]    imem_addr;
	instr_t                  imem_data;
	logic                    flags_write;
	flags_t                  flags_in;
	logic                    issue;
	logic [`PC_WIDTH-1:0]    issue_pc;
	instr_t                  issue_instr;
	logic                    halted;
	logic [`COUNT_WIDTH-1:0] instr_count;

	instr_t                  mem [0:255];
	logic [31:0]             rng;

	// Reference model state
	logic [`PC_WIDTH-1:0]    m_pc;
	flags_t                  m_flags;
	int                      m_bubble;
	logic                    m_halted;
	string                   m_ctx;
	logic                    exp_issue;
	instr_t                  exp_instr;
	logic [`COUNT_WIDTH-1:0] seen_count;

	fetch_top u_fetch_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.imem_addr   (imem_addr),
		.imem_data   (imem_data),
		.flags_write (flags_write),
		.flags_in    (flags_in),
		.issue       (issue),
		.issue_pc    (issue_pc),
		.issue_instr (issue_instr),
		.halted      (halted),
		.instr_count (instr_count)
	);

	assign imem_data = mem[imem_addr[8:1]];	// Combinational read

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic instr_t make_instr(input logic [3:0] op, input cond_e c,
		input logic [8:0] off);
		instr_t w;
		w.opcode = op;
		w.cond   = c;
		w.offset = off;
		return w;
	endfunction

	function automatic logic cond_holds(input cond_e c, input flags_t f);
		case (c)
			NEQ:     return !f.z;
			EQ:      return f.z;
			GT:      return !f.z && !f.n;
			LT:      return f.n;
			GEQ:     return f.z || !f.n;
			LEQ:     return f.z || f.n;
			OVFL:    return f.v;
			default: return 1'b1;
		endcase
	endfunction

	// PC+2 plus the word offset in bytes wrapped to 16 bits
	function automatic logic [`PC_WIDTH-1:0] branch_target(input logic [`PC_WIDTH-1:0] pc,
		input logic signed [8:0] off);
		return 16'(int'(pc) + 2 + 2 * int'(off));
	endfunction

	task automatic fail_check(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
		$display("=== FAIL ===");
		$fatal(1, "Stopped at first mismatch");
	endtask

	initial begin
		forever #20 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("=== FAIL ===");
		$fatal(1, "Watchdog expired");
	end

	// Random flag writes from the execute side
	always @(negedge clk) begin
		rng = xorshift32(rng);
		flags_write = rng[0];
		flags_in    = rng[3:1];
	end

	assign exp_issue = !m_halted && (m_bubble == 0);
	assign exp_instr = mem[m_pc[8:1]];

	always @(posedge clk) begin : model_step
		instr_t cur;
		if (!rst_n) begin
			m_pc     <= `PC_RESET;
			m_flags  <= '0;
			m_bubble <= 0;
			m_halted <= 1'b0;
			m_ctx    <= "reset";
		end else begin
			if (exp_issue) begin
				cur = mem[m_pc[8:1]];
				if (cur.opcode == `OP_HALT) begin
					m_halted <= 1'b1;	// PC stays on the halt
					m_ctx    <= "halt";
				end else if (cur.opcode == `OP_BRANCH && cond_holds(cur.cond, m_flags)) begin
					m_pc     <= branch_target(m_pc, cur.offset);
					m_bubble <= `BRANCH_PENALTY;
					m_ctx    <= "branch_taken";
				end else begin
					m_pc <= m_pc + 16'd2;
					if (cur.opcode == `OP_BRANCH) begin
						m_ctx <= "branch_not_taken";
					end else begin
						m_ctx <= "seq_fetch";
					end
				end
			end else if (m_bubble > 0) begin
				m_bubble <= m_bubble - 1;
			end
			if (flags_write) begin
				m_flags <= flags_in;	// Seen from the next branch on
			end
		end
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			seen_count <= '0;
		end else if (exp_issue) begin
			seen_count <= seen_count + 1'b1;
		end
	end

	issue_chk: assert property (@(negedge clk) disable iff (!rst_n) issue == exp_issue)
		else fail_check(m_ctx, exp_issue, issue);
	pc_chk: assert property (@(negedge clk) disable iff (!rst_n) !issue || issue_pc == m_pc)
		else fail_check(m_ctx, m_pc, issue_pc);
	instr_chk: assert property (@(negedge clk) disable iff (!rst_n)
		!exp_issue || issue_instr == exp_instr)
		else fail_check("issue_instr", exp_instr, issue_instr);
	halted_chk: assert property (@(negedge clk) disable iff (!rst_n) halted == m_halted)
		else fail_check(m_ctx, m_halted, halted);
	hold_chk: assert property (@(negedge clk) disable iff (!rst_n) !m_halted || imem_addr == m_pc)
		else fail_check("halt_hold", m_pc, imem_addr);
	count_chk: assert property (@(negedge clk) disable iff (!rst_n) instr_count == seen_count)
		else fail_check("count", seen_count, instr_count);

	initial begin
		rst_n       = 1'b0;
		flags_write = 1'b0;
		flags_in    = '0;
		rng         = 32'h26924380;
		for (int i = 0; i < 256; i++) begin
			rng = xorshift32(rng);
			if (rng[1:0] == 2'b00) begin
				mem[i] = make_instr(`OP_BRANCH, cond_e'(rng[4:2]), rng[13:5]);
			end else if (rng[7:4] == `OP_HALT || rng[7:4] == `OP_BRANCH) begin
				mem[i] = make_instr(4'h0, cond_e'(rng[10:8]), rng[19:11]);
			end else begin
				mem[i] = make_instr(rng[7:4], cond_e'(rng[10:8]), rng[19:11]);
			end
		end
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		while (seen_count < 16'd400) begin
			@(negedge clk);
		end

		// Short program that branches over one halt and stops at the next
		rst_n = 1'b0;
		for (int i = 0; i < 256; i++) begin
			mem[i] = make_instr(4'h0, NEQ, 9'd0);
		end
		mem[2] = make_instr(`OP_BRANCH, UNCOND, 9'd1);
		mem[3] = make_instr(`OP_HALT, NEQ, 9'd0);
		mem[5] = make_instr(`OP_HALT, NEQ, 9'd0);
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		repeat (30) @(negedge clk);

		if (halted !== 1'b1 || imem_addr !== HALT_ADDR) begin
			$display("The short program did not stop at its halt at address %0h", HALT_ADDR);
			$display("=== FAIL ===");
			$fatal(1, "Halt not reached");
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: fetch_top.f
+incdir+design
design/fetch_pkg.sv
design/pc_control.sv
design/bubble_timer.sv
design/fetch_sequencer.sv
design/pc_state.sv
design/fetch_top.sv
dv/fetch_tb.sv
